// ==== compile.f ====
design/mem_pkg.sv
design/access_timer.sv
design/sram_array.sv
design/axi_sram_fsm.sv
design/axi_sram_top.sv
verification/axi_sram_chk.sv
verification/tb_axi_sram.sv

// ==== design/access_timer.sv ====
`timescale 1ns/1ns

module access_timer #(
	parameter int unsigned WAIT_CYCLES = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic done
);

	// counter just wide enough for WAIT_CYCLES, at least one bit
	localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	// value loaded on start
	localparam logic [CW-1:0] LOAD = CW'(WAIT_CYCLES);

	logic [CW-1:0] cnt_q;
	logic          busy_q;
	logic          done_q;

	// done sits in the last cycle of the controller's WAIT state
	// so WAIT spans WAIT_CYCLES + 1 cycles from the loading edge
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q  <= '0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (start) begin
			cnt_q  <= LOAD;
			// zero wait states means done right after the load
			busy_q <= (WAIT_CYCLES != 0);
			done_q <= (WAIT_CYCLES == 0);
		end else if (busy_q) begin
			cnt_q <= cnt_q - CW'(1);
			// last step of the countdown
			if (cnt_q == CW'(1)) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end else begin
				done_q <= 1'b0;
			end
		end else begin
			// single cycle pulse
			done_q <= 1'b0;
		end
	end

	assign done = done_q;

endmodule

// ==== design/axi_sram_fsm.sv ====
`timescale 1ns/1ns

module axi_sram_fsm import mem_pkg::*; #(
	parameter int unsigned DEPTH = 256
) (
	input  logic     clk,
	input  logic     rst,

	// read address channel
	input  logic     ar_valid,
	input  ar_req_t  ar,
	output logic     ar_ready,

	// write address and data channels, accepted together
	input  logic     aw_valid,
	input  aw_req_t  aw,
	output logic     aw_ready,
	input  logic     w_valid,
	input  w_req_t   w,
	output logic     w_ready,

	// read data channel
	output logic     r_valid,
	output r_rsp_t   r,
	input  logic     r_ready,

	// write response channel
	output logic     b_valid,
	output b_rsp_t   b,
	input  logic     b_ready,

	// wait state timer
	output logic     timer_start,
	input  logic     timer_done,

	// storage array
	output mem_req_t mem_req,
	input  data_t    mem_rdata
);

	// array size as a word index, for the range check
	localparam addr_t LIMIT = addr_t'(DEPTH);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	// handshakes in IDLE
	logic  rd_acc;
	logic  wr_acc;
	logic  wr_ready;

	// word index of the incoming request
	addr_t idx_in;

	// latched request, payload part
	addr_t idx_q;
	data_t wdata_q;
	strb_t wstrb_q;

	// latched request, control part
	logic  is_rd_q;
	logic  hit_q;
	resp_t resp_q;

	// reads take priority, so a write waits while arvalid is high
	assign ar_ready = (state_q == IDLE);
	assign wr_ready = (state_q == IDLE) && !ar_valid && aw_valid && w_valid;
	assign aw_ready = wr_ready;
	assign w_ready  = wr_ready;

	assign rd_acc = ar_valid && ar_ready;
	assign wr_acc = aw_valid && aw_ready && w_valid && w_ready;

	// timer loads on the accepting edge
	assign timer_start = rd_acc || wr_acc;

	// low three address bits select a byte and are dropped
	assign idx_in = rd_acc ? (ar.addr >> 3) : (aw.addr >> 3);

	// next state
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (rd_acc || wr_acc) begin
					state_d = WAIT;
				end
			end
			WAIT: begin
				// wait states still running
				if (timer_done) begin
					state_d = ACCESS;
				end
			end
			ACCESS: begin
				// single cycle, array request goes out here
				state_d = is_rd_q ? RESP_R : RESP_B;
			end
			RESP_R: begin
				// hold until the master takes the read data
				if (r_ready) begin
					state_d = IDLE;
				end
			end
			RESP_B: begin
				// hold until the master takes the write response
				if (b_ready) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// state and control registers
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			is_rd_q <= 1'b0;
			hit_q   <= 1'b0;
			resp_q  <= RESP_OKAY;
		end else begin
			state_q <= state_d;
			if (rd_acc || wr_acc) begin
				is_rd_q <= rd_acc;
				hit_q   <= (idx_in < LIMIT);
			end
			// response code fixed when the access is done
			if (state_q == ACCESS) begin
				resp_q <= hit_q ? RESP_OKAY : RESP_SLVERR;
			end
		end
	end

	// request payload, captured at acceptance
	always_ff @(posedge clk) begin
		if (rd_acc || wr_acc) begin
			idx_q   <= idx_in;
			wdata_q <= w.data;
			wstrb_q <= w.strb;
		end
	end

	// array command, only in ACCESS and only when in range
	always_comb begin
		mem_req.en    = (state_q == ACCESS) && hit_q;
		mem_req.we    = !is_rd_q;
		mem_req.index = idx_q;
		mem_req.data  = wdata_q;
		mem_req.strb  = wstrb_q;
	end

	// valids decode straight from the state register
	assign r_valid = (state_q == RESP_R);
	assign b_valid = (state_q == RESP_B);

	// read data comes from the array output register
	// which holds its word since no new request goes out before IDLE
	// out-of-range reads return zero
	assign r.data = hit_q ? mem_rdata : '0;
	assign r.resp = resp_q;
	assign b.resp = resp_q;

endmodule

// ==== design/axi_sram_top.sv ====
`timescale 1ns/1ns

module axi_sram_top import mem_pkg::*; #(
	parameter int unsigned DEPTH       = 256,
	parameter int unsigned WAIT_CYCLES = 2
) (
	input  logic    clk,
	input  logic    rst,

	// read address channel
	input  logic    ar_valid,
	input  ar_req_t ar,
	output logic    ar_ready,

	// write address channel
	input  logic    aw_valid,
	input  aw_req_t aw,
	output logic    aw_ready,

	// write data channel
	input  logic    w_valid,
	input  w_req_t  w,
	output logic    w_ready,

	// read data channel
	output logic    r_valid,
	output r_rsp_t  r,
	input  logic    r_ready,

	// write response channel
	output logic    b_valid,
	output b_rsp_t  b,
	input  logic    b_ready
);

	// controller to timer
	logic     timer_start;
	logic     timer_done;

	// controller to array
	mem_req_t mem_req;
	data_t    mem_rdata;

	// channel handshakes, arbitration and sequencing
	axi_sram_fsm #(
		.DEPTH (DEPTH)
	) fsm_i (
		.clk         (clk),
		.rst         (rst),
		.ar_valid    (ar_valid),
		.ar          (ar),
		.ar_ready    (ar_ready),
		.aw_valid    (aw_valid),
		.aw          (aw),
		.aw_ready    (aw_ready),
		.w_valid     (w_valid),
		.w           (w),
		.w_ready     (w_ready),
		.r_valid     (r_valid),
		.r           (r),
		.r_ready     (r_ready),
		.b_valid     (b_valid),
		.b           (b),
		.b_ready     (b_ready),
		.timer_start (timer_start),
		.timer_done  (timer_done),
		.mem_req     (mem_req),
		.mem_rdata   (mem_rdata)
	);

	// access latency model
	access_timer #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) timer_i (
		.clk   (clk),
		.rst   (rst),
		.start (timer_start),
		.done  (timer_done)
	);

	// word storage
	sram_array #(
		.DEPTH (DEPTH)
	) array_i (
		.clk   (clk),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

endmodule

// ==== design/mem_pkg.sv ====
package mem_pkg;

	// byte address as seen on the bus
	typedef logic [31:0] addr_t;

	// one sram word, eight bytes wide
	typedef logic [63:0] data_t;

	// one strobe bit per data byte
	typedef logic [7:0] strb_t;

	// axi response code
	typedef logic [1:0] resp_t;

	// response codes in use
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// write address channel payload
	typedef struct packed {
		addr_t addr;
	} aw_req_t;

	// write data channel payload
	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_req_t;

	// read address channel payload
	typedef struct packed {
		addr_t addr;
	} ar_req_t;

	// read data channel payload
	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_rsp_t;

	// write response channel payload
	typedef struct packed {
		resp_t resp;
	} b_rsp_t;

	// controller command to the storage array
	// index is a word index, not a byte address
	typedef struct packed {
		logic  en;
		logic  we;
		addr_t index;
		data_t data;
		strb_t strb;
	} mem_req_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		ACCESS,
		RESP_R,
		RESP_B
	} ctrl_state_t;

endpackage

// ==== design/sram_array.sv ====
`timescale 1ns/1ns

module sram_array import mem_pkg::*; #(
	parameter int unsigned DEPTH = 256
) (
	input  logic     clk,
	input  mem_req_t req,
	output data_t    rdata
);

	// word select width, at least one bit for a one word array
	localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// number of byte lanes per word
	localparam int NB = $bits(strb_t);

	// storage, no reset
	data_t mem [DEPTH];

	// registered read port
	data_t rdata_q;

	// word select taken from the low index bits
	// the controller only issues in-range indices
	logic [IW-1:0] word_sel;

	assign word_sel = req.index[IW-1:0];

	// write takes effect at the request edge
	// only strobed lanes are updated
	always_ff @(posedge clk) begin
		if (req.en && req.we) begin
			for (int i = 0; i < NB; i++) begin
				if (req.strb[i]) begin
					mem[word_sel][8*i +: 8] <= req.data[8*i +: 8];
				end
			end
		end
	end

	// read word lands on rdata one cycle after the request
	// and holds until the next read request
	always_ff @(posedge clk) begin
		if (req.en && !req.we) begin
			rdata_q <= mem[word_sel];
		end
	end

	assign rdata = rdata_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the axi sram testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_axi_sram \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi

// ==== verification/axi_sram_chk.sv ====
`timescale 1ns/1ns

module axi_sram_chk import mem_pkg::*; (
	input logic   clk,
	input logic   rst,
	input logic   r_valid,
	input r_rsp_t r,
	input logic   r_ready,
	input logic   b_valid,
	input b_rsp_t b,
	input logic   b_ready,
	input logic   aw_ready,
	input logic   w_ready
);

	// failure counters, one per property, read by the testbench
	int unsigned r_err = 0;
	int unsigned b_err = 0;
	int unsigned aw_err = 0;
	int unsigned excl_err = 0;
	int unsigned err_cnt;

	assign err_cnt = r_err + b_err + aw_err + excl_err;

	// read response held until taken
	r_hold: assert property (@(posedge clk) disable iff (rst)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else begin
			r_err++;
			$error("read response dropped or changed before r_ready");
		end

	// write response held until taken
	b_hold: assert property (@(posedge clk) disable iff (rst)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else begin
			b_err++;
			$error("write response dropped or changed before b_ready");
		end

	// aw and w share one handshake
	aw_w_same: assert property (@(posedge clk) disable iff (rst)
		aw_ready == w_ready)
		else begin
			aw_err++;
			$error("aw_ready and w_ready differ");
		end

	// one transaction at a time
	rsp_excl: assert property (@(posedge clk) disable iff (rst)
		!(r_valid && b_valid))
		else begin
			excl_err++;
			$error("read and write responses valid together");
		end

endmodule

bind axi_sram_top axi_sram_chk chk_i (
	.clk      (clk),
	.rst      (rst),
	.r_valid  (r_valid),
	.r        (r),
	.r_ready  (r_ready),
	.b_valid  (b_valid),
	.b        (b),
	.b_ready  (b_ready),
	.aw_ready (aw_ready),
	.w_ready  (w_ready)
);

// ==== verification/tb_axi_sram.sv ====
`timescale 1ns/1ns

module tb_axi_sram import mem_pkg::*; ();

	localparam int DEPTH       = 256;
	localparam int WAIT_CYCLES = 2;
	localparam int IW          = $clog2(DEPTH);
	localparam int CLK_NS      = 8;
	localparam int RST_CYCLES  = 16;

	// transactions per test
	localparam int N_MERGE = 64;
	localparam int N_ERR   = 24;
	localparam int N_MIX   = 96;
	localparam int N_LAT   = 16;
	localparam int N_PAIR  = 16;
	localparam int NUM_TXN = 2 * DEPTH + 2 * N_MERGE + 2 * N_ERR + N_MIX + N_LAT + 3 * N_PAIR;

	// budget per transaction plus reset
	localparam int LIMIT_NS = NUM_TXN * (WAIT_CYCLES + 8) * CLK_NS + RST_CYCLES * CLK_NS;

	logic    clk;
	logic    rst;
	logic    ar_valid;
	ar_req_t ar;
	logic    ar_ready;
	logic    aw_valid;
	aw_req_t aw;
	logic    aw_ready;
	logic    w_valid;
	w_req_t  w;
	logic    w_ready;
	logic    r_valid;
	r_rsp_t  r;
	logic    r_ready;
	logic    b_valid;
	b_rsp_t  b;
	logic    b_ready;

	// reference memory
	data_t model [DEPTH];

	integer seed;
	string  cur_test;
	int     test_errs;
	int     tests_pass;
	int     tests_fail;

	axi_sram_top #(
		.DEPTH       (DEPTH),
		.WAIT_CYCLES (WAIT_CYCLES)
	) dut_i (
		.clk      (clk),
		.rst      (rst),
		.ar_valid (ar_valid),
		.ar       (ar),
		.ar_ready (ar_ready),
		.aw_valid (aw_valid),
		.aw       (aw),
		.aw_ready (aw_ready),
		.w_valid  (w_valid),
		.w        (w),
		.w_ready  (w_ready),
		.r_valid  (r_valid),
		.r        (r),
		.r_ready  (r_ready),
		.b_valid  (b_valid),
		.b        (b),
		.b_ready  (b_ready)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic data_t rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	// in-range word index
	function automatic addr_t rand_idx();
		return addr_t'($unsigned($random(seed)) % DEPTH);
	endfunction

	// ready delay, 0 to 3 cycles
	function automatic int rand_gap();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	// byte address of a word, low bits are don't care
	function automatic addr_t byte_addr(input addr_t idx);
		return (idx << 3) | addr_t'($unsigned($random(seed)) % 8);
	endfunction

	// strobed byte merge
	function automatic data_t merge(input data_t old, input data_t data, input strb_t strb);
		data_t m;
		m = old;
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				m[8*i +: 8] = data[8*i +: 8];
			end
		end
		return m;
	endfunction

	task automatic check(input string what, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			tests_pass++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_fail++;
			$display("test %s: %0d errors", cur_test, test_errs);
		end
		test_errs = 0;
	endtask

	// wait for accept, count latency at the ports, then take the response
	// entered between edges with the request already on the bus
	task automatic await_rsp(input logic is_rd, input data_t exp_data, input resp_t exp_resp,
			input int gap);
		logic acc;
		int   lat;
		lat = 0;
		acc = is_rd ? ar_ready : (aw_ready && w_ready);
		while (!acc) begin
			@(negedge clk);
			acc = is_rd ? ar_ready : (aw_ready && w_ready);
		end
		@(posedge clk);
		// accepting edge just passed
		if (is_rd) begin
			ar_valid <= 1'b0;
		end else begin
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end
		// lat counts edges after the accepting one
		@(negedge clk);
		while (!(is_rd ? r_valid : b_valid) && lat < WAIT_CYCLES + 8) begin
			@(negedge clk);
			lat++;
		end
		check("latency", data_t'(WAIT_CYCLES + 2), data_t'(lat));
		repeat (gap) @(posedge clk);
		@(posedge clk);
		if (is_rd) begin
			r_ready <= 1'b1;
		end else begin
			b_ready <= 1'b1;
		end
		@(negedge clk);
		if (is_rd) begin
			check("rresp", data_t'(exp_resp), data_t'(r.resp));
			check("rdata", exp_data, r.data);
		end else begin
			check("bresp", data_t'(exp_resp), data_t'(b.resp));
		end
		@(posedge clk);
		r_ready <= 1'b0;
		b_ready <= 1'b0;
		// exactly one response per transaction
		@(negedge clk);
		check("valid after transfer", 64'd0, data_t'(is_rd ? r_valid : b_valid));
	endtask

	task automatic do_write(input addr_t idx, input data_t d, input strb_t s, input int gap);
		logic hit;
		hit = (idx < DEPTH);
		@(posedge clk);
		aw_valid <= 1'b1;
		w_valid  <= 1'b1;
		aw.addr  <= byte_addr(idx);
		w.data   <= d;
		w.strb   <= s;
		@(negedge clk);
		await_rsp(1'b0, '0, hit ? RESP_OKAY : RESP_SLVERR, gap);
		// out-of-range writes leave the memory alone
		if (hit) begin
			model[idx[IW-1:0]] = merge(model[idx[IW-1:0]], d, s);
		end
	endtask

	task automatic do_read(input addr_t idx, input int gap);
		logic hit;
		hit = (idx < DEPTH);
		@(posedge clk);
		ar_valid <= 1'b1;
		ar.addr  <= byte_addr(idx);
		@(negedge clk);
		await_rsp(1'b1, hit ? model[idx[IW-1:0]] : '0, hit ? RESP_OKAY : RESP_SLVERR, gap);
	endtask

	// watchdog
	initial begin
		#(LIMIT_NS);
		$display("watchdog expired after %0d ns, a transaction never completed", LIMIT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		addr_t idx;
		addr_t oor;
		data_t d;
		strb_t s;
		int    chk_errs;
		seed       = 32'h4360_05ae;
		test_errs  = 0;
		tests_pass = 0;
		tests_fail = 0;
		clk        = 1'b0;
		rst        = 1'b1;
		ar_valid   = 1'b0;
		ar         = '0;
		aw_valid   = 1'b0;
		aw         = '0;
		w_valid    = 1'b0;
		w          = '0;
		r_ready    = 1'b0;
		b_ready    = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// idle after reset, then fill and read back every word
		cur_test = "reset_fill";
		@(negedge clk);
		check("r_valid after reset", 64'd0, data_t'(r_valid));
		check("b_valid after reset", 64'd0, data_t'(b_valid));
		for (int i = 0; i < DEPTH; i++) begin
			do_write(addr_t'(i), rand_data(), 8'hff, 0);
		end
		for (int i = 0; i < DEPTH; i++) begin
			do_read(addr_t'(i), 0);
		end
		end_test();

		// partial strobes merge into the stored word
		cur_test = "strobe_merge";
		for (int i = 0; i < N_MERGE; i++) begin
			idx = rand_idx();
			do_write(idx, rand_data(), strb_t'($random(seed)), rand_gap());
			do_read(idx, rand_gap());
		end
		end_test();

		// slverr above DEPTH, aliased word untouched
		cur_test = "out_of_range";
		for (int i = 0; i < N_ERR; i++) begin
			oor = addr_t'(DEPTH) + ($unsigned($random(seed)) % 32'h1000_0000);
			if ($random(seed) & 1) begin
				do_read(oor, rand_gap());
			end else begin
				do_write(oor, rand_data(), 8'hff, rand_gap());
			end
			do_read(oor % DEPTH, rand_gap());
		end
		end_test();

		// random read/write mix under ready back-pressure
		cur_test = "backpressure_mix";
		for (int i = 0; i < N_MIX; i++) begin
			if ($random(seed) & 1) begin
				do_read(rand_idx(), rand_gap());
			end else begin
				do_write(rand_idx(), rand_data(), strb_t'($random(seed)), rand_gap());
			end
		end
		end_test();

		// back to back, latency counted in every transaction
		cur_test = "latency";
		for (int i = 0; i < N_LAT; i++) begin
			if (i % 2 == 0) begin
				do_write(rand_idx(), rand_data(), 8'hff, 0);
			end else begin
				do_read(rand_idx(), 0);
			end
		end
		end_test();

		// read and write on the same edge, read goes first
		cur_test = "read_write_collision";
		for (int i = 0; i < N_PAIR; i++) begin
			idx = rand_idx();
			d = rand_data();
			s = strb_t'($random(seed));
			@(posedge clk);
			ar_valid <= 1'b1;
			ar.addr  <= byte_addr(idx);
			aw_valid <= 1'b1;
			w_valid  <= 1'b1;
			aw.addr  <= byte_addr(idx);
			w.data   <= d;
			w.strb   <= s;
			@(negedge clk);
			// old word expected, write still pending
			await_rsp(1'b1, model[idx[IW-1:0]], RESP_OKAY, rand_gap());
			await_rsp(1'b0, '0, RESP_OKAY, rand_gap());
			model[idx[IW-1:0]] = merge(model[idx[IW-1:0]], d, s);
			do_read(idx, rand_gap());
		end
		end_test();

		chk_errs = int'(dut_i.chk_i.err_cnt);
		$display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
			tests_pass, tests_fail, chk_errs);
		if (tests_fail == 0 && chk_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
